// File: build.f
hw/plic_pkg.sv
hw/plic_bus_pkg.sv
hw/plic_gateways.sv
hw/plic_regs.sv
hw/plic_arbiter.sv
hw/plic_top.sv
sim/plic_tb.sv

// File: hw/plic_arbiter.sv
`timescale 1ns/1ps

// Interrupt arbiter
// Picks the enabled pending source with the highest nonzero priority,
// lowest id on a tie, and raises the interrupt above the threshold

module plic_arbiter (
	input  plic_pkg::source_mask_t    i_pending,
	input  plic_pkg::source_mask_t    i_enable,
	input  plic_pkg::priority_array_t i_priorities,
	input  plic_pkg::priority_t       i_threshold,
	output plic_pkg::source_id_t      o_winner,
	output logic                      o_interrupt
);

	import plic_pkg::*;

	source_mask_t candidates;
	source_id_t   best_id;
	priority_t    best_priority;

	assign candidates = i_pending & i_enable;

	always_comb begin
		best_id       = '0;
		best_priority = '0;

		// Strict compare keeps the lowest id among equals
		for (int i = 0; i < num_sources; i++) begin
			if (candidates[i] && (i_priorities[i] > best_priority)) begin
				best_priority = i_priorities[i];
				best_id       = source_id_t'(i + 1);
			end
		end
	end

	// Winner is reported even at or below the threshold
	assign o_winner = best_id;

	assign o_interrupt = (best_id != '0) && (best_priority > i_threshold);

endmodule

// File: hw/plic_bus_pkg.sv
// CPU bus definitions for the interrupt controller
// Strobe bus word types, the request bundle and the register address map

package plic_bus_pkg;

	typedef logic [23:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// Raised by the CPU and held until ready
	typedef struct packed {
		logic      request;
		logic      rw;       // 1 means write
		bus_addr_t address;
		bus_data_t wdata;
	} bus_req_t;

	// Register map for the single hart context
	localparam bus_addr_t addr_priority_base = 24'h000000; // Source n at base + 4n
	localparam bus_addr_t addr_pending       = 24'h001000; // Read only, bits 1 to 4
	localparam bus_addr_t addr_enable        = 24'h002000; // Bits 1 to 4
	localparam bus_addr_t addr_threshold     = 24'h200000;
	localparam bus_addr_t addr_claim         = 24'h200004; // Read claims, write completes

endpackage

// File: hw/plic_gateways.sv
`timescale 1ns/1ps

// Interrupt gateways
// Detects rising edges on the raw sources and latches them as pending.
// A source in service ignores new edges until it is completed.

module plic_gateways (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  plic_pkg::source_mask_t i_sources,       // Asynchronous raw inputs
	input  plic_pkg::source_mask_t i_enable,
	input  plic_pkg::source_mask_t i_claim_mask,
	input  plic_pkg::source_mask_t i_complete_mask,
	output plic_pkg::source_mask_t o_pending
);

	import plic_pkg::*;

	source_mask_t       sync_q;        // First capture of the raw inputs
	source_mask_t [1:0] history_q;     // Entry 0 is the newer sample
	source_mask_t       pending_q;
	source_mask_t       in_service_q;
	source_mask_t       rise_mask;
	source_mask_t       new_mask;

	// Low then high in the history
	always_comb begin
		rise_mask = history_q[0] & ~history_q[1];
		new_mask  = rise_mask & i_enable & ~in_service_q;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sync_q       <= '0;
			history_q    <= '0;
			pending_q    <= '0;
			in_service_q <= '0;
		end
		else begin
			sync_q    <= i_sources;
			history_q <= {history_q[0], sync_q};

			// Claim wins over an edge arriving on the same cycle
			pending_q <= (pending_q | new_mask) & ~i_claim_mask;

			// Completion of an idle source has no effect
			in_service_q <= (in_service_q & ~i_complete_mask) | i_claim_mask;
		end
	end

	assign o_pending = pending_q;

endmodule

// File: hw/plic_pkg.sv
// Interrupt side definitions for the interrupt controller
// Source count, id and priority widths and the per-source types

package plic_pkg;

	localparam int num_sources    = 4;
	localparam int priority_width = 3;
	localparam int id_width       = 3;

	// One bit per source, bit 0 is source id 1
	typedef logic [num_sources-1:0] source_mask_t;

	// Zero means no source, 1 to 4 name a source
	typedef logic [id_width-1:0] source_id_t;

	// Zero means never interrupt
	typedef logic [priority_width-1:0] priority_t;

	// Entry 0 belongs to source id 1
	typedef priority_t [num_sources-1:0] priority_array_t;

endpackage

// File: hw/plic_regs.sv
`timescale 1ns/1ps

// Register block of the interrupt controller
// Answers the CPU strobe bus, holds priority, enable and threshold,
// and turns claim reads and completion writes into one-cycle masks

module plic_regs (
	input  logic                      i_clock,
	input  logic                      i_reset,
	input  plic_bus_pkg::bus_req_t    i_bus,
	input  plic_pkg::source_id_t      i_winner,
	input  plic_pkg::source_mask_t    i_pending,
	output plic_bus_pkg::bus_data_t   o_rdata,
	output logic                      o_ready,
	output plic_pkg::source_mask_t    o_enable,
	output plic_pkg::priority_array_t o_priorities,
	output plic_pkg::priority_t       o_threshold,
	output plic_pkg::source_mask_t    o_claim_mask,
	output plic_pkg::source_mask_t    o_complete_mask
);

	import plic_pkg::*;
	import plic_bus_pkg::*;

	source_mask_t    enable_q;
	priority_array_t priorities_q;
	priority_t       threshold_q;
	logic            accept;
	logic            do_read;
	logic            do_write;
	logic            hit_claim;
	bus_data_t       read_data;

	// Address of the priority register for mask index idx
	function automatic bus_addr_t priority_addr(input int idx);
		return addr_priority_base + bus_addr_t'(4 * (idx + 1));
	endfunction

	// One-hot mask for a source id, empty for 0 and ids past the last source
	function automatic source_mask_t id_to_mask(input source_id_t id);
		source_mask_t mask;
		for (int i = 0; i < num_sources; i++) begin
			mask[i] = (id == source_id_t'(i + 1));
		end
		return mask;
	endfunction

	always_comb begin
		accept    = i_bus.request && !o_ready;
		do_read   = accept && !i_bus.rw;
		do_write  = accept && i_bus.rw;
		hit_claim = (i_bus.address == addr_claim);
	end

	// Readback mux, unmapped addresses read as zero
	always_comb begin
		read_data = '0;
		for (int i = 0; i < num_sources; i++) begin
			if (i_bus.address == priority_addr(i)) begin
				read_data = bus_data_t'(priorities_q[i]);
			end
		end
		if (i_bus.address == addr_pending) begin
			read_data = bus_data_t'({i_pending, 1'b0});
		end
		else if (i_bus.address == addr_enable) begin
			read_data = bus_data_t'({enable_q, 1'b0});
		end
		else if (i_bus.address == addr_threshold) begin
			read_data = bus_data_t'(threshold_q);
		end
		else if (hit_claim) begin
			read_data = bus_data_t'(i_winner);   // Current best pending source
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			enable_q        <= '0;
			priorities_q    <= '0;
			threshold_q     <= '0;
			o_ready         <= 1'b0;
			o_rdata         <= '0;
			o_claim_mask    <= '0;
			o_complete_mask <= '0;
		end
		else begin
			o_ready         <= accept;
			o_rdata         <= do_read ? read_data : '0;
			o_claim_mask    <= '0;
			o_complete_mask <= '0;

			if (do_read && hit_claim) begin
				o_claim_mask <= id_to_mask(i_winner);   // Empty when nothing wins
			end

			if (do_write) begin
				for (int i = 0; i < num_sources; i++) begin
					if (i_bus.address == priority_addr(i)) begin
						priorities_q[i] <= i_bus.wdata[priority_width-1:0];
					end
				end
				if (i_bus.address == addr_enable) begin
					enable_q <= i_bus.wdata[num_sources:1];
				end
				if (i_bus.address == addr_threshold) begin
					threshold_q <= i_bus.wdata[priority_width-1:0];
				end
				if (hit_claim) begin
					o_complete_mask <= id_to_mask(i_bus.wdata[id_width-1:0]);
				end
			end
		end
	end

	assign o_enable     = enable_q;
	assign o_priorities = priorities_q;
	assign o_threshold  = threshold_q;

endmodule

// File: hw/plic_top.sv
`timescale 1ns/1ps

// Platform-level interrupt controller, four sources and one hart context
// Gateways and register block run side by side, the arbiter joins them

module plic_top (
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  plic_pkg::source_mask_t  i_sources,
	input  plic_bus_pkg::bus_req_t  i_bus,
	output plic_bus_pkg::bus_data_t o_rdata,
	output logic                    o_ready,
	output logic                    o_interrupt
);

	import plic_pkg::*;

	source_mask_t    pending;
	source_mask_t    enable;
	source_mask_t    claim_mask;
	source_mask_t    complete_mask;
	priority_array_t priorities;
	priority_t       threshold;
	source_id_t      winner;

	plic_gateways plic_gateways_inst (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_sources       (i_sources),
		.i_enable        (enable),
		.i_claim_mask    (claim_mask),
		.i_complete_mask (complete_mask),
		.o_pending       (pending)
	);

	plic_regs plic_regs_inst (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_bus           (i_bus),
		.i_winner        (winner),
		.i_pending       (pending),
		.o_rdata         (o_rdata),
		.o_ready         (o_ready),
		.o_enable        (enable),
		.o_priorities    (priorities),
		.o_threshold     (threshold),
		.o_claim_mask    (claim_mask),
		.o_complete_mask (complete_mask)
	);

	plic_arbiter plic_arbiter_inst (
		.i_pending    (pending),
		.i_enable     (enable),
		.i_priorities (priorities),
		.i_threshold  (threshold),
		.o_winner     (winner),
		.o_interrupt  (o_interrupt)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the interrupt controller testbench with Verilator and runs it.
# The exit status is the simulator's own, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	-f build.f \
	--top-module plic_tb \
	--Mdir obj_dir \
	-o plic_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/plic_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi

exit 0

// File: sim/plic_tb.sv
`timescale 1ns/1ps

// Testbench for the platform-level interrupt controller
// Drives the strobe bus and the raw sources and checks against a reference model

module plic_tb;

	import plic_pkg::*;
	import plic_bus_pkg::*;

	localparam int bus_timeout   = 20;
	localparam int settle_cycles = 4;
	localparam int random_rounds = 300;

	logic         i_clock;
	logic         i_reset;
	source_mask_t i_sources;
	bus_req_t     i_bus;
	bus_data_t    o_rdata;
	logic         o_ready;
	logic         o_interrupt;

	// Reference model state
	source_mask_t    model_enable;
	priority_array_t model_priorities;
	priority_t       model_threshold;
	source_mask_t    model_pending;
	source_mask_t    model_in_service;
	logic [15:0]     lfsr_q;
	bus_data_t       rdata;

	plic_top plic_top_inst (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_sources   (i_sources),
		.i_bus       (i_bus),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.o_interrupt (o_interrupt)
	);

	initial i_clock = 1'b0;
	always #10 i_clock = ~i_clock;

	// Taps for x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	function automatic bus_data_t random_bits(input int n);
		bus_data_t value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);   // One step per bit
			value  = {value[30:0], lfsr_q[0]};
		end
		return value;
	endfunction

	// Scans from the highest priority down and the lowest id up
	function automatic source_id_t model_winner();
		source_id_t   winner;
		source_mask_t eligible;
		winner   = '0;
		eligible = model_pending & model_enable;
		for (int p = 7; p >= 1 && winner == '0; p--) begin
			for (int i = 0; i < num_sources && winner == '0; i++) begin
				if (eligible[i] && model_priorities[i] == priority_t'(p)) begin
					winner = source_id_t'(i + 1);
				end
			end
		end
		return winner;
	endfunction

	function automatic logic model_irq();
		source_id_t winner;
		winner = model_winner();
		if (winner == '0) begin
			return 1'b0;
		end
		return model_priorities[int'(winner) - 1] > model_threshold;
	endfunction

	function automatic bus_addr_t priority_addr(input int idx);
		return addr_priority_base + bus_addr_t'(4 * (idx + 1));   // Source id is idx + 1
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_data(input bus_data_t got, input bus_data_t expected, input string what);
		if (got !== expected) begin
			stop_run($sformatf("error at %0t ns: %s read %h, expected %h",
				$time, what, got, expected));
		end
	endtask

	task automatic check_id(input source_id_t got, input source_id_t expected, input string what);
		if (got !== expected) begin
			stop_run($sformatf("error at %0t ns: %s returned id %0d, expected %0d",
				$time, what, got, expected));
		end
	endtask

	task automatic check_irq(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			stop_run($sformatf("error at %0t ns: %s interrupt line is %b, expected %b",
				$time, what, got, expected));
		end
	endtask

	task automatic settle();
		repeat (settle_cycles) @(posedge i_clock);
		#2;
	endtask

	// One strobe bus transfer with request dropped in the ready cycle
	task automatic bus_access(input logic rw, input bus_addr_t address, input bus_data_t wdata,
		output bus_data_t data);
		int cycles;
		@(posedge i_clock);
		#2;
		i_bus.request = 1'b1;
		i_bus.rw      = rw;
		i_bus.address = address;
		i_bus.wdata   = wdata;
		cycles = 0;
		do begin
			@(posedge i_clock);
			#2;
			cycles++;
		end while (!o_ready && cycles < bus_timeout);
		if (!o_ready) begin
			stop_run("The bus request got no ready pulse within 20 cycles");
		end
		data = o_rdata;
		i_bus.request = 1'b0;
	endtask

	task automatic bus_write(input bus_addr_t address, input bus_data_t wdata);
		bus_data_t ignored;
		bus_access(1'b1, address, wdata, ignored);
	endtask

	task automatic bus_read(input bus_addr_t address, output bus_data_t data);
		bus_access(1'b0, address, '0, data);
	endtask

	task automatic write_priority(input int idx, input bus_data_t value);
		bus_write(priority_addr(idx), value);
		model_priorities[idx] = value[priority_width-1:0];
	endtask

	task automatic write_enable(input bus_data_t value);
		bus_write(addr_enable, value);
		model_enable = value[num_sources:1];   // Bit 0 is not a source
	endtask

	task automatic write_threshold(input bus_data_t value);
		bus_write(addr_threshold, value);
		model_threshold = value[priority_width-1:0];
	endtask

	// Drives new source levels and records rising edges in the model
	task automatic drive_sources(input source_mask_t levels);
		source_mask_t rising;
		rising = levels & ~i_sources;
		@(posedge i_clock);
		#2;
		i_sources = levels;
		model_pending = model_pending | (rising & model_enable & ~model_in_service);
		settle();
	endtask

	task automatic claim_and_check();
		source_id_t expected;
		expected = model_winner();
		bus_read(addr_claim, rdata);
		check_id(source_id_t'(rdata), expected, "claim");
		check_data(rdata >> id_width, '0, "claim upper bits");
		if (expected != '0) begin
			model_pending[int'(expected) - 1]    = 1'b0;
			model_in_service[int'(expected) - 1] = 1'b1;
		end
	endtask

	task automatic complete(input source_id_t id);
		bus_write(addr_claim, bus_data_t'(id));
		if (int'(id) >= 1 && int'(id) <= num_sources) begin
			model_in_service[int'(id) - 1] = 1'b0;   // No effect when idle
		end
	endtask

	task automatic check_state(input string what);
		settle();
		check_irq(o_interrupt, model_irq(), what);
		bus_read(addr_pending, rdata);
		check_data(rdata, bus_data_t'({model_pending, 1'b0}), {what, " pending"});
	endtask

	initial begin
		lfsr_q           = 16'd26280;
		i_reset          = 1'b1;
		i_sources        = '0;
		i_bus            = '0;
		model_enable     = '0;
		model_priorities = '0;
		model_threshold  = '0;
		model_pending    = '0;
		model_in_service = '0;
		repeat (2) @(posedge i_clock);
		#2;
		i_reset = 1'b0;
		check_data(o_rdata, '0, "read data after reset");
		check_irq(o_interrupt, 1'b0, "after reset");

		// Configuration readback masked to the register widths
		for (int round = 0; round < 8; round++) begin
			for (int idx = 0; idx < num_sources; idx++) begin
				write_priority(idx, random_bits(32));
			end
			write_enable(random_bits(32));
			write_threshold(random_bits(32));
			for (int idx = 0; idx < num_sources; idx++) begin
				bus_read(priority_addr(idx), rdata);
				check_data(rdata, bus_data_t'(model_priorities[idx]), "priority");
			end
			bus_read(addr_enable, rdata);
			check_data(rdata, bus_data_t'({model_enable, 1'b0}), "enable");
			bus_read(addr_threshold, rdata);
			check_data(rdata, bus_data_t'(model_threshold), "threshold");
		end
		bus_read(24'h000000, rdata);   // Source 0 does not exist
		check_data(rdata, '0, "unmapped 0x000000");
		bus_read(24'h000014, rdata);
		check_data(rdata, '0, "unmapped 0x000014");
		bus_read(24'h200008, rdata);
		check_data(rdata, '0, "unmapped 0x200008");

		// Directed edges, claims and completions
		write_threshold(32'd0);
		write_priority(0, 32'd3);
		write_priority(1, 32'd5);
		write_priority(2, 32'd6);
		write_priority(3, 32'd2);
		write_enable(bus_data_t'({4'b0011, 1'b0}));
		drive_sources(4'b0101);        // Source 3 is disabled
		check_state("edges on sources 1 and 3");
		claim_and_check();
		check_state("after claim of source 1");
		drive_sources(4'b0000);
		drive_sources(4'b0001);        // Ignored while in service
		check_state("edge while in service");
		complete(3'd2);                // Wrong id leaves source 1 in service
		drive_sources(4'b0000);
		drive_sources(4'b0001);
		check_state("edge after wrong completion");
		complete(3'd1);
		check_state("held level after completion");
		drive_sources(4'b0000);
		drive_sources(4'b0001);
		check_state("edge after completion");
		claim_and_check();
		claim_and_check();             // Nothing left
		complete(3'd1);

		// Random mix of edges, configuration, claims and completions
		for (int round = 0; round < random_rounds; round++) begin
			case (random_bits(3))
				0, 1, 2: drive_sources(source_mask_t'(random_bits(num_sources)));
				3:       write_priority(int'(random_bits(2)), random_bits(3));
				4:       write_enable(random_bits(5));
				5:       write_threshold(random_bits(3));
				6:       claim_and_check();
				default: complete(source_id_t'(random_bits(3)));
			endcase
			check_state($sformatf("random round %0d", round));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule
